// ==== src/mlp_pkg.sv ====
`default_nettype none

package mlp_pkg;

    // network shape
    localparam int num_inputs  = 2;
    localparam int num_hidden  = 3;
    localparam int num_outputs = 15;

    // fixed point, weights are Q9.7
    localparam int data_w    = 24;
    localparam int weight_w  = 16;
    localparam int frac_bits = 7;

    typedef logic signed [data_w-1:0]   data_t;    // inputs, activations, scores
    typedef logic signed [weight_w-1:0] weight_t;  // weights and biases
    typedef logic signed [2*data_w-1:0] product_t; // full multiply result
    typedef logic [$clog2(num_outputs)-1:0] class_idx_t;

    localparam data_t data_min = {1'b1, {(data_w-1){1'b0}}}; // most negative score

    // controller phases
    typedef enum logic [2:0] {
        idle,
        hidden_mul,
        hidden_sum,
        output_mul,
        output_sum,
        scan,
        done_hold
    } mlp_state_e;

    // drop the fraction bits of a product and keep the activation width
    function automatic data_t reduce_product(input product_t p);
        return p[frac_bits +: data_w]; // bits 30:7
    endfunction

    // hidden layer, one row per neuron, one column per input
    localparam weight_t hidden_weights [num_hidden][num_inputs] = '{
        '{16'h0032, 16'hFFEA},  //  0.3906 -0.1719
        '{16'hFFF6, 16'h005F},  // -0.0781  0.7422
        '{16'hFFB8, 16'h0062}   // -0.5625  0.7656
    };

    localparam weight_t hidden_biases [num_hidden] = '{
        16'hFBAA,  // -8.6719
        16'hFE84,  // -2.9688
        16'h07DA   // 15.7031
    };

    // output layer, one row per class
    localparam weight_t output_weights [num_outputs][num_hidden] = '{
        '{16'h0040, 16'hFFE3, 16'h00CE},  // class 0, also the regression neuron
        '{16'hF89B, 16'h0209, 16'hFEC1},
        '{16'hFEB1, 16'h0082, 16'hFFB1},
        '{16'hFF75, 16'h006C, 16'hFFAA},
        '{16'hFFDC, 16'h0011, 16'hEAEE},
        '{16'h0034, 16'h0000, 16'hF52C},
        '{16'h005A, 16'h0014, 16'h0029},
        '{16'hFF9E, 16'h0066, 16'hFFCD},
        '{16'hFFD3, 16'hFF1D, 16'hFFD3},
        '{16'hFFCE, 16'hFEB4, 16'hE351},
        '{16'h001F, 16'hFF21, 16'hF64E},
        '{16'hFFF2, 16'hFFA0, 16'hD835},
        '{16'h003D, 16'hFFBD, 16'hF083},
        '{16'h0070, 16'hFF91, 16'hFF6D},
        '{16'h009C, 16'hFFDE, 16'hFE3A}   // class 14
    };

    localparam weight_t output_biases [num_outputs] = '{
        16'hFB48,  // -9.4375
        16'h1174,  // 34.9062, largest bias so it wins when all activations are zero
        16'h0802,
        16'h03A5,
        16'h053B,
        16'hFAAF,
        16'hEED2,
        16'hFF66,
        16'h0B76,
        16'h0EA9,
        16'h063F,
        16'h08A5,
        16'hFF7B,
        16'hF731,
        16'hE796   // -48.8281
    };

endpackage

`default_nettype wire

// ==== src/hidden_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hidden_layer (
    input  logic           clk,
    input  logic           rst,
    input  logic           hidden_mul_en, // capture products
    input  logic           hidden_sum_en, // bias, sum and relu
    input  mlp_pkg::data_t in_a,
    input  mlp_pkg::data_t in_b,
    output mlp_pkg::data_t hidden_act [mlp_pkg::num_hidden]
);
    import mlp_pkg::*;

    data_t    in_vec   [num_inputs];             // inputs as an indexable vector
    product_t hid_prod [num_hidden][num_inputs]; // registered products
    data_t    hid_sum  [num_hidden];             // pre-activation sums

    assign in_vec[0] = in_a;
    assign in_vec[1] = in_b;

    // multiply stage, inputs are sampled here
    always_ff @(posedge clk) begin
        if (hidden_mul_en) begin
            for (int h = 0; h < num_hidden; h++) begin
                for (int i = 0; i < num_inputs; i++) begin
                    hid_prod[h][i] <= in_vec[i] * hidden_weights[h][i]; // 24x16 signed
                end
            end
        end
    end

    // bias plus reduced products, wraps at 24 bits
    always_comb begin
        for (int h = 0; h < num_hidden; h++) begin
            hid_sum[h] = data_t'(hidden_biases[h]); // sign extended
            for (int i = 0; i < num_inputs; i++) begin
                hid_sum[h] = hid_sum[h] + reduce_product(hid_prod[h][i]);
            end
        end
    end

    // relu and activation register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hidden_act <= '{default: '0};
        end else if (hidden_sum_en) begin
            for (int h = 0; h < num_hidden; h++) begin
                hidden_act[h] <= hid_sum[h][data_w-1] ? '0 : hid_sum[h]; // clamp negatives
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/output_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_layer (
    input  logic           clk,
    input  logic           rst,
    input  logic           output_mul_en, // capture products
    input  logic           output_sum_en, // bias and sum
    input  mlp_pkg::data_t hidden_act [mlp_pkg::num_hidden],
    output mlp_pkg::data_t scores     [mlp_pkg::num_outputs]
);
    import mlp_pkg::*;

    product_t out_prod [num_outputs][num_hidden]; // 45 registered products
    data_t    out_sum  [num_outputs];

    // multiply stage
    always_ff @(posedge clk) begin
        if (output_mul_en) begin
            for (int o = 0; o < num_outputs; o++) begin
                for (int h = 0; h < num_hidden; h++) begin
                    out_prod[o][h] <= hidden_act[h] * output_weights[o][h];
                end
            end
        end
    end

    // no activation on the output layer, raw scores
    always_comb begin
        for (int o = 0; o < num_outputs; o++) begin
            out_sum[o] = data_t'(output_biases[o]);
            for (int h = 0; h < num_hidden; h++) begin
                out_sum[o] = out_sum[o] + reduce_product(out_prod[o][h]); // modulo 2^24
            end
        end
    end

    // score registers, score 0 doubles as regression output
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scores <= '{default: data_min};
        end else if (output_sum_en) begin
            for (int o = 0; o < num_outputs; o++) begin
                scores[o] <= out_sum[o];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/argmax_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module argmax_scan (
    input  logic                clk,
    input  logic                rst,
    input  logic                scan_start, // one cycle, scores are stable
    input  mlp_pkg::data_t      scores [mlp_pkg::num_outputs],
    output mlp_pkg::class_idx_t class_index,
    output logic                scan_done   // high in the last compare cycle
);
    import mlp_pkg::*;

    logic       busy;    // compare cycles in progress
    class_idx_t pos;     // score under compare
    data_t      max_val; // running maximum

    assign scan_done = busy && (pos == class_idx_t'(num_outputs - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            pos         <= '0;
            max_val     <= data_min;
            class_index <= '0;
        end else if (scan_start) begin
            // seed with score 0, compares start at position 1
            busy        <= 1'b1;
            pos         <= class_idx_t'(1);
            max_val     <= scores[0];
            class_index <= '0;
        end else if (busy) begin
            // strict compare so a tie keeps the lower index
            if (scores[pos] > max_val) begin
                max_val     <= scores[pos];
                class_index <= pos;
            end
            if (scan_done) begin
                busy <= 1'b0; // index now holds until the next scan
            end else begin
                pos <= pos + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/mlp_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mlp_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic start,         // level
    input  logic scan_done,
    output logic hidden_mul_en,
    output logic hidden_sum_en,
    output logic output_mul_en,
    output logic output_sum_en,
    output logic scan_start,    // first cycle of scan
    output logic done
);
    import mlp_pkg::*;

    mlp_state_e state;
    mlp_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            idle:       if (start) state_nxt = hidden_mul;
            hidden_mul: state_nxt = hidden_sum;
            hidden_sum: state_nxt = output_mul;
            output_mul: state_nxt = output_sum;
            output_sum: state_nxt = scan;
            scan:       if (scan_done) state_nxt = done_hold; // last compare
            done_hold:  if (!start) state_nxt = idle;          // wait for release
            default:    state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= idle;
            scan_start <= 1'b0;
        end else begin
            state      <= state_nxt;
            scan_start <= (state == output_sum); // scores land on this edge
        end
    end

    // one strobe per layer phase
    assign hidden_mul_en = (state == hidden_mul);
    assign hidden_sum_en = (state == hidden_sum);
    assign output_mul_en = (state == output_mul);
    assign output_sum_en = (state == output_sum);

    assign done = (state == done_hold); // class index is final here

endmodule

`default_nettype wire

// ==== src/mlp_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module mlp_classifier (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,            // level, hold until done
    input  mlp_pkg::data_t      in_a,             // stable from start to done
    input  mlp_pkg::data_t      in_b,
    output mlp_pkg::class_idx_t class_index,
    output mlp_pkg::data_t      regression_score, // raw score of neuron 0
    output logic                done
);
    import mlp_pkg::*;

    logic  hidden_mul_en;
    logic  hidden_sum_en;
    logic  output_mul_en;
    logic  output_sum_en;
    logic  scan_start;
    logic  scan_done;
    data_t hidden_act [num_hidden];
    data_t scores     [num_outputs];

    mlp_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .scan_done     (scan_done),
        .hidden_mul_en (hidden_mul_en),
        .hidden_sum_en (hidden_sum_en),
        .output_mul_en (output_mul_en),
        .output_sum_en (output_sum_en),
        .scan_start    (scan_start),
        .done          (done)
    );

    hidden_layer u_hidden_layer (
        .clk           (clk),
        .rst           (rst),
        .hidden_mul_en (hidden_mul_en),
        .hidden_sum_en (hidden_sum_en),
        .in_a          (in_a),
        .in_b          (in_b),
        .hidden_act    (hidden_act)
    );

    output_layer u_output_layer (
        .clk           (clk),
        .rst           (rst),
        .output_mul_en (output_mul_en),
        .output_sum_en (output_sum_en),
        .hidden_act    (hidden_act),
        .scores        (scores)
    );

    argmax_scan u_argmax_scan (
        .clk         (clk),
        .rst         (rst),
        .scan_start  (scan_start),
        .scores      (scores),
        .class_index (class_index),
        .scan_done   (scan_done)
    );

    assign regression_score = scores[0]; // regression reuses the classifier weights

endmodule

`default_nettype wire

// ==== verification/tb_mlp_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mlp_classifier;
    import mlp_pkg::*;

    localparam int  num_vectors      = 10;
    localparam int  words_per_vector = 4;  // in_a, in_b, class, score
    localparam int  clk_period       = 40;
    localparam time drive_delay      = 2;  // inputs change this long after posedge
    localparam int  reset_cycles     = 16;
    localparam int  cycle_limit      = num_vectors * 40 + 100;

    logic       clk;
    logic       rst;
    logic       start;
    data_t      in_a;
    data_t      in_b;
    class_idx_t class_index;
    data_t      regression_score;
    logic       done;

    logic [data_w-1:0] stim_mem [0:num_vectors*words_per_vector-1]; // raw file words
    int                cycle_count = 0;

    mlp_classifier u_mlp_classifier (
        .clk              (clk),
        .rst              (rst),
        .start            (start),
        .in_a             (in_a),
        .in_b             (in_b),
        .class_index      (class_index),
        .regression_score (regression_score),
        .done             (done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // global watchdog covering every wait below
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: no verdict after %0d clock cycles", cycle_count);
            $display("Some tests failed");
            $fatal(1, "run stopped by the watchdog");
        end
    end

    // one clock, then settle past the edge before sampling or driving
    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_class(input string name, input class_idx_t expected,
                               input class_idx_t actual);
        if (actual !== expected) begin
            $display("FAILED %s expected 0x%h got 0x%h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_score(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("FAILED %s expected 0x%h got 0x%h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s expected 0x%h got 0x%h", name, expected, actual);
            stop_run();
        end
    endtask

    // reset values of the outputs
    task automatic check_reset_outputs();
        check_level("done", 1'b0, done);
        check_class("class_index", '0, class_index);
        check_score("regression_score", data_min, regression_score);
    endtask

    task automatic wait_for_done();
        while (done !== 1'b1) begin
            next_cycle(); // watchdog ends a hung run
        end
    endtask

    initial begin
        int         gap;
        int         hold;
        data_t      exp_score;
        class_idx_t exp_class;

        rst   = 1'b1;
        start = 1'b0;
        in_a  = '0;
        in_b  = '0;

        void'($urandom(96765)); // seeds the generator for the idle gaps
        $readmemh("verification/mlp_stimulus.txt", stim_mem);
        if ($isunknown(stim_mem[num_vectors*words_per_vector-1])) begin
            $display("stimulus file is missing or holds fewer than %0d vectors", num_vectors);
            stop_run();
        end

        // outputs sit at reset values the whole time rst is high
        repeat (reset_cycles) begin
            next_cycle();
            check_reset_outputs();
        end
        rst = 1'b0;
        next_cycle();
        check_reset_outputs(); // and right after release

        for (int v = 0; v < num_vectors; v++) begin
            gap = int'($urandom % 4); // 0..3 idle cycles
            repeat (gap) next_cycle();

            in_a      = stim_mem[words_per_vector*v];
            in_b      = stim_mem[words_per_vector*v+1];
            exp_class = class_idx_t'(stim_mem[words_per_vector*v+2]);
            exp_score = stim_mem[words_per_vector*v+3];

            check_level("done", 1'b0, done); // previous run fully released
            start = 1'b1;
            wait_for_done();
            check_class("class_index", exp_class, class_index);
            check_score("regression_score", exp_score, regression_score);

            // start held past done must not begin a second run
            hold = 1 + v % 3;
            repeat (hold) begin
                next_cycle();
                check_level("done", 1'b1, done);
                check_class("class_index", exp_class, class_index);
                check_score("regression_score", exp_score, regression_score);
            end

            start = 1'b0;
            next_cycle();
            check_level("done", 1'b0, done);  // back in idle
            check_class("class_index", exp_class, class_index); // results held
            check_score("regression_score", exp_score, regression_score);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/mlp_stimulus.txt ====
// columns: in_a in_b expected_class expected_regression_score
// all hex, 24-bit two's complement inputs and score, score is output neuron 0
000000 000000 8 0007EA  // only hidden 2 active from its bias
000000 000500 0 000D92  // hidden 1 and 2 active
003200 000000 A 0002E1  // only hidden 0 active
0005DC FFF830 1 FFFB48  // every hidden sum negative, scores are biases
006400 000000 D 000CA5  // larger hidden 0
005280 003200 7 FFFE51  // hidden 0 and 1, hidden 2 clamped
000000 000086 0 00088F  // classes 0 and 8 tie at 0x88F, lower index wins
01F400 000000 E 005AC5  // hidden 0 dominant
0003E8 FFF448 1 FFFB48  // second all-negative hidden case
003200 000000 A 0002E1  // repeat after a clamped run

// ==== sources.f ====
src/mlp_pkg.sv
src/hidden_layer.sv
src/output_layer.sv
src/argmax_scan.sv
src/mlp_sequencer.sv
src/mlp_classifier.sv
verification/tb_mlp_classifier.sv

// ==== Bender.yml ====
package:
  name: mlp_classifier

sources:
  - src/mlp_pkg.sv
  - src/hidden_layer.sv
  - src/output_layer.sv
  - src/argmax_scan.sv
  - src/mlp_sequencer.sv
  - src/mlp_classifier.sv
  - target: test
    files:
      - verification/tb_mlp_classifier.sv
